// ==== flist.f ====
rtl/mmu_pkg.sv
rtl/tlb_entry_array.sv
rtl/tlb_lookup.sv
rtl/mmu_translate.sv
rtl/mmu_top.sv
test/tb_mmu.sv

// ==== test/mmu_vectors.txt ====
# W <index> <entry: asid(2) g+vpn2(5) pfn1(6) then d1 v1 pfn0 d0 v0 packed in 7 hex digits>
# L <name> <vaddr> <asid> <is_store> <exc> <paddr> <index>, all hex
# exc codes 0 none, 1 refill, 2 invalid, 3 modified
# paddr is compared only when exc is 0, index only for a mapped address that hit
# One line per clock cycle, so consecutive L lines are issued back to back
#
# Entry 3: asid 11, vpn2 00012, odd pfn 000abc valid dirty, even pfn 000123 valid dirty
W 3 1100012000ABCC00048F
# Entry 15: global, vpn2 60000, odd pfn f12345 valid dirty, even pfn 054321 valid clean
W f 00E0000F12345C150C85
# Entry 7: asid 22, vpn2 00100, odd page invalid, even pfn 00fedc valid dirty
W 7 2200100000777003FB73
#
# Even and odd hits, both halves of one entry
L even_hit 00024568 11 0 0 00123568 3
L odd_hit 00025ffc 11 0 0 00abcffc 3
L odd_store_dirty 00025010 11 1 0 00abc010 3
#
# ASID versus global match
L foreign_asid 00024000 22 0 1 00000000 0
L global_odd c0001abc 5a 0 0 12345abc f
L global_even_load c0000100 77 0 0 54321100 f
L global_asid_zero c0000ffc 00 0 0 54321ffc f
#
# Invalid and modified
L global_even_store c0000200 77 1 3 00000000 f
L invalid_odd 00201234 22 0 2 00000000 7
L invalid_odd_store 00201ff0 22 1 2 00000000 7
L c_even_hit 00200abc 22 0 0 0fedcabc 7
L c_even_store 00200004 22 1 0 0fedc004 7
L c_wrong_asid 00200abc 11 0 1 00000000 0
L no_entry 7fffe000 00 0 1 00000000 0
#
# Unmapped segments bypass the TLB
L kseg0_plain 80001234 00 0 0 00001234 0
L kseg1_plain bfc00180 00 1 0 1fc00180 0
# Entry 9: global, vpn2 40000 covers kseg0 base, both pages invalid
W 9 00C00000AAAAA0155554
L kseg0_over_invalid 80000010 00 1 0 00000010 0
L kseg1_high bfffffff 3c 0 0 1fffffff 0
#
# Overwrites seen by the lookup in the very next cycle
W 3 1100012000ABCC02FBBF
L overwrite_same 00024568 11 0 0 0beef568 3
L overwrite_odd_keep 00025ffc 11 0 0 00abcffc 3
# Entry 7 replaced: asid 33, vpn2 00300, odd pfn 000042, even pfn 000024, all valid dirty
W 7 3300300000042C000093
L overwrite_new 00601008 33 0 0 00042008 7
L overwrite_old_gone 00200abc 22 0 1 00000000 0
#
# Back-to-back lookups of mixed kinds
L pipe_a 00600024 33 1 0 00024024 7
L pipe_b c0001000 01 0 0 12345000 f
L pipe_c 00024004 11 0 0 0beef004 3
L pipe_d a0000004 00 0 0 00000004 0
L pipe_e 00025000 44 0 1 00000000 0
L pipe_f c0000300 12 1 3 00000000 f
L pipe_g 00601ffc 33 1 0 00042ffc 7
L pipe_h 9fc00000 00 0 0 1fc00000 0

// ==== test/tb_mmu.sv ====
// MMU testbench; reads test/mmu_vectors.txt from the project root, one vector line per clock cycle
`timescale 1ns/1ps

module tb_mmu
    import mmu_pkg::*;
();

    logic       clk = 1'b0;
    logic       rst;
    logic       tlb_we;
    tlb_index_t tlb_windex;
    tlb_entry_t tlb_wentry;
    logic       lookup_valid;
    vaddr_t     vaddr;
    asid_t      asid;
    logic       is_store;
    logic       resp_valid;
    paddr_t     paddr;
    exc_code_t  exc_code;
    tlb_index_t resp_index;

    // Commands read from the vector file, one entry per line
    logic [7:0]   cmd_kind_q  [$];
    logic [191:0] cmd_name_q  [$];
    logic [31:0]  cmd_addr_q  [$];
    logic [79:0]  cmd_entry_q [$];
    logic [7:0]   cmd_asid_q  [$];
    logic         cmd_store_q [$];
    logic [1:0]   cmd_exc_q   [$];
    logic [31:0]  cmd_paddr_q [$];
    logic [3:0]   cmd_index_q [$];

    // Outstanding lookups, oldest first
    logic [191:0] exp_name_q  [$];
    logic [31:0]  exp_vaddr_q [$];
    logic [1:0]   exp_exc_q   [$];
    logic [31:0]  exp_paddr_q [$];
    logic [3:0]   exp_index_q [$];

    logic lookup_seen = 1'b0;
    logic vectors_ready = 1'b0;

    mmu_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .tlb_we       (tlb_we),
        .tlb_windex   (tlb_windex),
        .tlb_wentry   (tlb_wentry),
        .lookup_valid (lookup_valid),
        .vaddr        (vaddr),
        .asid         (asid),
        .is_store     (is_store),
        .resp_valid   (resp_valid),
        .paddr        (paddr),
        .exc_code     (exc_code),
        .resp_index   (resp_index)
    );

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    function automatic logic is_unmapped(input logic [31:0] va);
        return (va[31:29] == seg_kseg0_c) || (va[31:29] == seg_kseg1_c);
    endfunction

    ////////////////////
    // Vector reader
    ////////////////////

    task automatic load_vectors();
        int           fd;
        int           n;
        logic [8*160-1:0] line;
        logic [63:0]  tok;
        logic [191:0] name;
        logic [31:0]  f_addr;
        logic [79:0]  f_entry;
        logic [31:0]  f_asid;
        logic [31:0]  f_store;
        logic [31:0]  f_exc;
        logic [31:0]  f_paddr;
        logic [31:0]  f_index;
        fd = $fopen("test/mmu_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file test/mmu_vectors.txt");
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                tok = '0;
                name = '0;
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%s", tok);
                end
                if (n == 1 && tok == "W") begin
                    n = $sscanf(line, "%s %h %h", tok, f_addr, f_entry);
                    if (n != 3) begin
                        $display("Malformed write line in the vector file");
                        abort_run();
                    end
                    cmd_kind_q.push_back("W");
                    cmd_name_q.push_back('0);
                    cmd_addr_q.push_back(f_addr);
                    cmd_entry_q.push_back(f_entry);
                    cmd_asid_q.push_back('0);
                    cmd_store_q.push_back(1'b0);
                    cmd_exc_q.push_back('0);
                    cmd_paddr_q.push_back('0);
                    cmd_index_q.push_back('0);
                end else if (n == 1 && tok == "L") begin
                    n = $sscanf(line, "%s %s %h %h %h %h %h %h", tok, name, f_addr,
                                f_asid, f_store, f_exc, f_paddr, f_index);
                    if (n != 8) begin
                        $display("Malformed lookup line in the vector file");
                        abort_run();
                    end
                    cmd_kind_q.push_back("L");
                    cmd_name_q.push_back(name);
                    cmd_addr_q.push_back(f_addr);
                    cmd_entry_q.push_back('0);
                    cmd_asid_q.push_back(f_asid[7:0]);
                    cmd_store_q.push_back(f_store[0]);
                    cmd_exc_q.push_back(f_exc[1:0]);
                    cmd_paddr_q.push_back(f_paddr);
                    cmd_index_q.push_back(f_index[3:0]);
                end else if (n == 1 && tok != "#") begin
                    $display("Unrecognised line in the vector file");
                    abort_run();
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////
    // Driver
    ////////////////////

    task automatic apply_command(input int i);
        logic [31:0] a;
        a = cmd_addr_q[i];
        tlb_we       <= 1'b0;
        lookup_valid <= 1'b0;
        if (cmd_kind_q[i] == "W") begin
            tlb_we     <= 1'b1;
            tlb_windex <= a[3:0];
            tlb_wentry <= cmd_entry_q[i];
        end else begin
            lookup_valid <= 1'b1;
            vaddr        <= a;
            asid         <= cmd_asid_q[i];
            is_store     <= cmd_store_q[i];
            exp_name_q.push_back(cmd_name_q[i]);
            exp_vaddr_q.push_back(a);
            exp_exc_q.push_back(cmd_exc_q[i]);
            exp_paddr_q.push_back(cmd_paddr_q[i]);
            exp_index_q.push_back(cmd_index_q[i]);
        end
    endtask

    initial begin
        rst          = 1'b1;
        tlb_we       = 1'b0;
        tlb_windex   = '0;
        tlb_wentry   = '0;
        lookup_valid = 1'b0;
        vaddr        = '0;
        asid         = '0;
        is_store     = 1'b0;
        load_vectors();
        vectors_ready = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < cmd_kind_q.size(); i++) begin
            @(posedge clk);
            apply_command(i);
        end
        @(posedge clk);
        tlb_we       <= 1'b0;
        lookup_valid <= 1'b0;
        repeat (2) @(posedge clk);
        if (exp_name_q.size() != 0) begin
            $display("%0d lookups never received a response", exp_name_q.size());
            abort_run();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

    ////////////////////
    // Checker
    ////////////////////

    task automatic check_response();
        logic [191:0] name;
        logic [31:0]  exp_vaddr;
        logic [1:0]   exp_exc;
        logic [31:0]  exp_paddr;
        logic [3:0]   exp_index;
        if (exp_name_q.size() == 0) begin
            $display("A response arrived while no lookup was outstanding");
            abort_run();
        end else begin
            name      = exp_name_q.pop_front();
            exp_vaddr = exp_vaddr_q.pop_front();
            exp_exc   = exp_exc_q.pop_front();
            exp_paddr = exp_paddr_q.pop_front();
            exp_index = exp_index_q.pop_front();
            assert (exc_code === exp_exc) else begin
                $display("ERROR %0s: exc_code expected %0d actual %0d", name, exp_exc, exc_code);
                abort_run();
            end
            // The physical address means nothing once an exception is raised
            if (exp_exc == exc_none) begin
                assert (paddr === exp_paddr) else begin
                    $display("ERROR %0s: paddr expected %h actual %h", name, exp_paddr, paddr);
                    abort_run();
                end
            end
            // Index is only defined for a mapped address that hit
            if (exp_exc != exc_refill && !is_unmapped(exp_vaddr)) begin
                assert (resp_index === exp_index) else begin
                    $display("ERROR %0s: resp_index expected %0d actual %0d",
                             name, exp_index, resp_index);
                    abort_run();
                end
            end
        end
    endtask

    // Outputs are sampled mid-cycle, where they are settled
    always @(negedge clk) begin
        if (!rst) begin
            assert (resp_valid === lookup_seen) else begin
                $display("resp_valid is %b one cycle after lookup_valid was %b",
                         resp_valid, lookup_seen);
                abort_run();
            end
            if (resp_valid === 1'b1) begin
                check_response();
            end
        end
        lookup_seen = lookup_valid;
    end

    ////////////////////
    // Watchdog
    ////////////////////

    initial begin
        wait (vectors_ready);
        repeat (cmd_kind_q.size() * 4 + 100) @(posedge clk);
        $display("Watchdog expired before all vectors were applied and answered");
        abort_run();
    end

endmodule

// ==== rtl/mmu_top.sv ====
// MMU top; one lookup per cycle, response exactly one cycle later, ASID supplied by the caller
`timescale 1ns/1ps

module mmu_top
    import mmu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tlb_we,
    input  tlb_index_t tlb_windex,
    input  tlb_entry_t tlb_wentry,
    input  logic       lookup_valid,
    input  vaddr_t     vaddr,
    input  asid_t      asid,
    input  logic       is_store,
    output logic       resp_valid,
    output paddr_t     paddr,
    output exc_code_t  exc_code,
    output tlb_index_t resp_index
);

    tlb_entry_t entries [tlb_entries_c];
    logic       hit;
    tlb_index_t hit_index;
    pfn_t       page_pfn;
    logic       page_dirty;
    logic       page_valid;

    tlb_entry_array u_entry_array (
        .clk        (clk),
        .rst        (rst),
        .tlb_we     (tlb_we),
        .tlb_windex (tlb_windex),
        .tlb_wentry (tlb_wentry),
        .entries    (entries)
    );

    tlb_lookup u_lookup (
        .clk          (clk),
        .lookup_valid (lookup_valid),
        .entries      (entries),
        .vaddr        (vaddr),
        .asid         (asid),
        .hit          (hit),
        .hit_index    (hit_index),
        .page_pfn     (page_pfn),
        .page_dirty   (page_dirty),
        .page_valid   (page_valid)
    );

    mmu_translate u_translate (
        .clk          (clk),
        .rst          (rst),
        .lookup_valid (lookup_valid),
        .vaddr        (vaddr),
        .is_store     (is_store),
        .hit          (hit),
        .hit_index    (hit_index),
        .page_pfn     (page_pfn),
        .page_dirty   (page_dirty),
        .page_valid   (page_valid),
        .resp_valid   (resp_valid),
        .paddr        (paddr),
        .exc_code     (exc_code),
        .resp_index   (resp_index)
    );

endmodule

// ==== rtl/mmu_translate.sv ====
// Registered response one cycle after each request; no back-pressure, so every response must be taken
`timescale 1ns/1ps

module mmu_translate
    import mmu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       lookup_valid,
    input  vaddr_t     vaddr,
    input  logic       is_store,
    input  logic       hit,
    input  tlb_index_t hit_index,
    input  pfn_t       page_pfn,
    input  logic       page_dirty,
    input  logic       page_valid,
    output logic       resp_valid,
    output paddr_t     paddr,
    output exc_code_t  exc_code,
    output tlb_index_t resp_index
);

    logic      unmapped;
    paddr_t    paddr_next;
    exc_code_t exc_next;

    ////////////////////
    // Segment decode
    ////////////////////

    // kseg0 and kseg1 bypass the TLB entirely
    assign unmapped = (vaddr[31:29] == seg_kseg0_c) || (vaddr[31:29] == seg_kseg1_c);

    always_comb begin
        if (unmapped) begin
            paddr_next = {3'b000, vaddr[28:0]};
            exc_next   = exc_none;
        end else begin
            paddr_next = {page_pfn[19:0], vaddr[11:0]};
            if (!hit) begin
                exc_next = exc_refill;
            end else if (!page_valid) begin
                exc_next = exc_invalid;
            end else if (is_store && !page_dirty) begin
                exc_next = exc_modified;
            end else begin
                exc_next = exc_none;
            end
        end
    end

    ////////////////////
    // Response register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= lookup_valid;
        end
    end

    // Payload only moves with a request
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            paddr      <= paddr_next;
            exc_code   <= exc_next;
            resp_index <= hit_index;
        end
    end

    // resp_valid must be clean once out of reset
    a_resp_valid_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(resp_valid)
    ) else $error("resp_valid is unknown after reset");

endmodule

// ==== rtl/tlb_lookup.sv ====
// Combinational lookup over all 16 entries; duplicate matches are illegal and resolve to the lowest
`timescale 1ns/1ps

module tlb_lookup
    import mmu_pkg::*;
(
    input  logic       clk,
    input  logic       lookup_valid,
    input  tlb_entry_t entries [tlb_entries_c],
    input  vaddr_t     vaddr,
    input  asid_t      asid,
    output logic       hit,
    output tlb_index_t hit_index,
    output pfn_t       page_pfn,
    output logic       page_dirty,
    output logic       page_valid
);

    logic [tlb_entries_c-1:0] match;
    vpn2_t                    req_vpn2;
    tlb_entry_t               sel_entry;
    logic                     odd_page;

    // VPN2 names a pair of 4 KB pages, bit 12 picks the half
    assign req_vpn2 = vaddr[31:13];
    assign odd_page = vaddr[12];

    ////////////////////
    // Parallel compare
    ////////////////////

    for (genvar i = 0; i < tlb_entries_c; i++) begin : g_match
        logic vpn2_eq;
        logic asid_ok;

        assign vpn2_eq = entries[i][vpn2_msb:vpn2_lsb] == req_vpn2;

        // Global entries ignore the address space
        assign asid_ok = (entries[i][asid_msb:asid_lsb] == asid) || entries[i][global_bit];

        assign match[i] = vpn2_eq && asid_ok;
    end

    assign hit = |match;

    ////////////////////
    // Priority select
    ////////////////////

    // Scanning downward lets the lowest matching index overwrite the others
    always_comb begin
        hit_index = '0;
        for (int i = tlb_entries_c - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_index = tlb_index_t'(i);
            end
        end
    end

    assign sel_entry = entries[hit_index];

    ////////////////////
    // Page pick
    ////////////////////

    always_comb begin
        if (odd_page) begin
            page_pfn   = sel_entry[pfn1_lsb +: $bits(pfn_t)];
            page_dirty = sel_entry[d1_bit];
            page_valid = sel_entry[v1_bit];
        end else begin
            page_pfn   = sel_entry[pfn0_lsb +: $bits(pfn_t)];
            page_dirty = sel_entry[d0_bit];
            page_valid = sel_entry[v0_bit];
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Software must never load two entries that map the same page pair
    a_no_duplicate: assert property (
        @(posedge clk)
        lookup_valid |-> $onehot0(match)
    ) else $error("Multiple TLB entries match vaddr %h asid %h", vaddr, asid);

endmodule

// ==== rtl/tlb_entry_array.sv ====
// Entry storage written by index; a write is visible to lookups from the following cycle on
`timescale 1ns/1ps

module tlb_entry_array
    import mmu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tlb_we,
    input  tlb_index_t tlb_windex,
    input  tlb_entry_t tlb_wentry,
    output tlb_entry_t entries [tlb_entries_c]
);

    ////////////////////
    // Entry registers
    ////////////////////

    // All entries come out of reset as zero, which leaves both pages invalid
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < tlb_entries_c; i++) begin
                entries[i] <= '0;
            end
        end else if (tlb_we) begin
            entries[tlb_windex] <= tlb_wentry;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // An unknown index would corrupt an unpredictable entry
    a_windex_known: assert property (
        @(posedge clk) disable iff (rst)
        tlb_we |-> !$isunknown(tlb_windex)
    ) else $error("tlb_windex is unknown during a TLB write");

endmodule

// ==== rtl/mmu_pkg.sv ====
// Shared MMU types and constants; 4 KB pages only, TLB entries use the 80-bit jointly tagged layout
package mmu_pkg;

    ////////////////////
    // Widths that carry a meaning
    ////////////////////

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [7:0]  asid_t;
    typedef logic [18:0] vpn2_t;

    // Only the low 20 bits of a stored PFN reach the physical address
    typedef logic [23:0] pfn_t;

    typedef logic [79:0] tlb_entry_t;
    typedef logic [3:0]  tlb_index_t;

    localparam int tlb_entries_c = 16;

    ////////////////////
    // Entry field positions
    ////////////////////

    localparam int asid_msb   = 79;
    localparam int asid_lsb   = 72;
    localparam int global_bit = 71;
    localparam int vpn2_msb   = 70;
    localparam int vpn2_lsb   = 52;

    // Odd page, selected by vaddr bit 12 set
    localparam int pfn1_lsb   = 28;
    localparam int d1_bit     = 27;
    localparam int v1_bit     = 26;

    // Even page
    localparam int pfn0_lsb   = 2;
    localparam int d0_bit     = 1;
    localparam int v0_bit     = 0;

    ////////////////////
    // Unmapped segments and exceptions
    ////////////////////

    localparam logic [2:0] seg_kseg0_c = 3'b100;
    localparam logic [2:0] seg_kseg1_c = 3'b101;

    typedef enum logic [1:0] {
        exc_none     = 2'd0,
        exc_refill   = 2'd1,
        exc_invalid  = 2'd2,
        exc_modified = 2'd3
    } exc_code_t;

endpackage
